/* common/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// unified memory depth in words, byte address is 10 bits
`define RV_MEM_WORDS 256

// request queue entries, also the arbiter's starting credit count
`define RV_MEM_QUEUE_DEPTH 2

// cycles from queue exit to read response
`define RV_MEM_LATENCY 3

`endif

/* common/rv_pkg.sv */
package rv_pkg;

    // rv32i major opcodes used by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EX1,
        S_EX2,
        S_MEM,
        S_MEM_WAIT,
        S_WB,
        S_HALT
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // second alu operand select
    localparam logic [1:0] SRC_B_REG  = 2'd0;
    localparam logic [1:0] SRC_B_IMM  = 2'd1;
    localparam logic [1:0] SRC_B_FOUR = 2'd2;

    typedef enum logic [1:0] {
        LOADER,
        FETCH,
        DATA
    } requester_e;

    typedef struct packed {
        logic       fetch_req;
        logic       ir_write;
        logic       data_req;
        logic       data_write;
        logic       alu_src_a_pc;
        logic [1:0] alu_src_b_sel;
        alu_op_e    alu_op;
        logic       result_latch;
        logic       reg_write;
        logic       wb_sel_mem;
        logic       wb_sel_link;
        logic       pc_write;
        logic       pc_write_cond;
        logic       retire;
    } ctrl_word_t;

endpackage

/* common/mem_port_if.sv */
`include "rv_settings.svh"

interface mem_port_if;

    logic                req_valid;
    logic                req_ready;
    logic                req_write;
    logic [`RV_XLEN-1:0] req_addr;
    logic [`RV_XLEN-1:0] req_wdata;
    logic                rsp_valid;
    logic [`RV_XLEN-1:0] rsp_rdata;
    logic                credit_return;

    // core side, request held until req_ready
    modport requester (
        output req_valid, req_write, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport arb_side (
        input  req_valid, req_write, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_rdata
    );

    // credit flow, req_ready is advisory only here
    modport mem_master (
        output req_valid, req_write, req_addr, req_wdata,
        input  req_ready, rsp_valid, rsp_rdata, credit_return
    );

    modport mem_slave (
        input  req_valid, req_write, req_addr, req_wdata,
        output req_ready, rsp_valid, rsp_rdata, credit_return
    );

endinterface

/* control/control_unit.sv */
module control_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  rv_pkg::opcode_e    opcode,
    input  logic [2:0]         funct3,
    input  logic               funct7_5,
    input  logic               fetch_rsp_valid,
    input  logic               data_rsp_valid,
    input  logic               fetch_accept,
    input  logic               data_accept,
    input  logic               branch_taken,
    output rv_pkg::ctrl_word_t ctrl,
    output logic               halted
);

    rv_pkg::ctrl_state_e state;
    rv_pkg::ctrl_state_e next_state;
    rv_pkg::alu_op_e     alu_fn;
    logic                started;
    logic                is_load;
    logic                is_store;
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;

    assign is_load   = opcode == rv_pkg::LOAD;
    assign is_store  = opcode == rv_pkg::STORE;
    assign is_branch = opcode == rv_pkg::BRANCH;
    assign is_jal    = opcode == rv_pkg::JAL;
    assign is_jalr   = opcode == rv_pkg::JALR;
    assign halted    = state == rv_pkg::S_HALT;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= rv_pkg::S_FETCH;
            started <= 1'b0;
        end else begin
            state   <= next_state;
            started <= started | start;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rv_pkg::S_FETCH: begin
                if (fetch_accept)
                    next_state = rv_pkg::S_FETCH_WAIT;
            end
            rv_pkg::S_FETCH_WAIT: begin
                if (fetch_rsp_valid)
                    next_state = rv_pkg::S_DECODE;
            end
            rv_pkg::S_DECODE: next_state = rv_pkg::S_EX1;
            rv_pkg::S_EX1:    next_state = rv_pkg::S_EX2;
            rv_pkg::S_EX2: begin
                if (is_branch)
                    next_state = rv_pkg::S_FETCH;
                else if (is_load || is_store)
                    next_state = rv_pkg::S_MEM;
                else if (opcode == rv_pkg::SYSTEM)
                    next_state = rv_pkg::S_HALT;
                else
                    next_state = rv_pkg::S_WB;
            end
            rv_pkg::S_MEM: begin
                if (data_accept)
                    next_state = is_store ? rv_pkg::S_FETCH : rv_pkg::S_MEM_WAIT;
            end
            rv_pkg::S_MEM_WAIT: begin
                if (data_rsp_valid)
                    next_state = rv_pkg::S_WB;
            end
            rv_pkg::S_WB:   next_state = rv_pkg::S_FETCH;
            rv_pkg::S_HALT: next_state = rv_pkg::S_HALT;
            default:        next_state = rv_pkg::S_FETCH;
        endcase
    end

    // alu function for register and immediate arithmetic, add otherwise
    always_comb begin
        alu_fn = rv_pkg::ALU_ADD;
        if (opcode == rv_pkg::OP || opcode == rv_pkg::OP_IMM) begin
            case (funct3)
                3'b000: begin
                    if (opcode == rv_pkg::OP && funct7_5)
                        alu_fn = rv_pkg::ALU_SUB;
                end
                3'b010:  alu_fn = rv_pkg::ALU_SLT;
                3'b100:  alu_fn = rv_pkg::ALU_XOR;
                3'b110:  alu_fn = rv_pkg::ALU_OR;
                3'b111:  alu_fn = rv_pkg::ALU_AND;
                default: alu_fn = rv_pkg::ALU_ADD;
            endcase
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = rv_pkg::ALU_ADD;
        case (state)
            rv_pkg::S_FETCH:      ctrl.fetch_req = started;
            rv_pkg::S_FETCH_WAIT: ctrl.ir_write = fetch_rsp_valid;
            rv_pkg::S_EX1: begin
                // next sequential pc, or the jal target
                ctrl.alu_src_a_pc  = 1'b1;
                ctrl.alu_src_b_sel = is_jal ? rv_pkg::SRC_B_IMM : rv_pkg::SRC_B_FOUR;
                ctrl.pc_write      = 1'b1;
            end
            rv_pkg::S_EX2: begin
                ctrl.alu_op        = alu_fn;
                ctrl.alu_src_a_pc  = is_branch;
                ctrl.alu_src_b_sel = (opcode == rv_pkg::OP) ? rv_pkg::SRC_B_REG
                                                            : rv_pkg::SRC_B_IMM;
                ctrl.result_latch  = 1'b1;
                ctrl.pc_write_cond = is_branch;
                ctrl.pc_write      = is_jalr || branch_taken;
                ctrl.retire        = is_branch;
            end
            rv_pkg::S_MEM: begin
                ctrl.data_req   = 1'b1;
                ctrl.data_write = is_store;
                ctrl.retire     = is_store && data_accept;
            end
            rv_pkg::S_WB: begin
                ctrl.reg_write   = 1'b1;
                ctrl.wb_sel_mem  = is_load;
                ctrl.wb_sel_link = is_jal || is_jalr;
                ctrl.retire      = 1'b1;
            end
            default: ctrl.alu_op = rv_pkg::ALU_ADD;
        endcase
    end

endmodule

/* datapath/datapath.sv */
`include "rv_settings.svh"

module datapath (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::ctrl_word_t  ctrl,
    output rv_pkg::opcode_e     opcode,
    output logic [2:0]          funct3,
    output logic                funct7_5,
    output logic                branch_taken,
    output logic                fetch_accept,
    output logic                data_accept,
    output logic                fetch_rsp_valid,
    output logic                data_rsp_valid,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data,
    mem_port_if.requester       fetch,
    mem_port_if.requester       data
);

    localparam int XLEN = `RV_XLEN;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] old_pc;
    logic [XLEN-1:0] ir;
    logic [XLEN-1:0] reg_a;
    logic [XLEN-1:0] reg_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] mdr;
    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] rf_a;
    logic [XLEN-1:0] rf_b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] link;
    logic [XLEN-1:0] wb_data;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;

    assign opcode   = rv_pkg::opcode_e'(ir[6:0]);
    assign funct3   = ir[14:12];
    assign funct7_5 = ir[30];
    assign rd       = ir[11:7];
    assign rs1      = ir[19:15];
    assign rs2      = ir[24:20];

    // x0 reads as zero
    assign rf_a = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rf_b = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_comb begin
        case (opcode)
            rv_pkg::STORE:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            rv_pkg::BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            rv_pkg::JAL:    imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:        imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    // old_pc is the address of the instruction being executed
    assign alu_a = ctrl.alu_src_a_pc ? old_pc : reg_a;

    always_comb begin
        case (ctrl.alu_src_b_sel)
            rv_pkg::SRC_B_IMM:  alu_b = imm;
            rv_pkg::SRC_B_FOUR: alu_b = XLEN'(4);
            default:            alu_b = reg_b;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_SUB: alu_result = alu_a - alu_b;
            rv_pkg::ALU_AND: alu_result = alu_a & alu_b;
            rv_pkg::ALU_OR:  alu_result = alu_a | alu_b;
            rv_pkg::ALU_XOR: alu_result = alu_a ^ alu_b;
            rv_pkg::ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            default:         alu_result = alu_a + alu_b;
        endcase
    end

    // beq and bne only, qualified by the branch evaluation step
    assign branch_taken = ctrl.pc_write_cond && ((reg_a == reg_b) ^ funct3[0]);

    assign link    = old_pc + XLEN'(4);
    assign wb_data = ctrl.wb_sel_mem  ? mdr  :
                     ctrl.wb_sel_link ? link : alu_out;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= '0;
        else if (ctrl.pc_write)
            pc <= {alu_result[XLEN-1:1], 1'b0};
    end

    always_ff @(posedge clk) begin
        reg_a <= rf_a;
        reg_b <= rf_b;
        if (ctrl.ir_write) begin
            ir     <= fetch.rsp_rdata;
            old_pc <= pc;
        end
        if (ctrl.result_latch)
            alu_out <= alu_result;
        if (data_rsp_valid)
            mdr <= data.rsp_rdata;
        if (ctrl.reg_write && rd != 5'd0)
            regs[rd] <= wb_data;
    end

    assign fetch.req_valid = ctrl.fetch_req;
    assign fetch.req_write = 1'b0;
    assign fetch.req_addr  = pc;
    assign fetch.req_wdata = '0;
    assign data.req_valid  = ctrl.data_req;
    assign data.req_write  = ctrl.data_write;
    assign data.req_addr   = alu_out;
    assign data.req_wdata  = reg_b;

    assign fetch_accept    = fetch.req_valid && fetch.req_ready;
    assign data_accept     = data.req_valid && data.req_ready;
    assign fetch_rsp_valid = fetch.rsp_valid;
    assign data_rsp_valid  = data.rsp_valid;

    // one trace beat per instruction, a cycle after it completes
    always_ff @(posedge clk) begin
        if (reset)
            retire_valid <= 1'b0;
        else
            retire_valid <= ctrl.retire;
    end

    always_ff @(posedge clk) begin
        if (ctrl.retire) begin
            retire_pc <= old_pc;
            retire_rd <= ctrl.reg_write ? rd : 5'd0;
            if (ctrl.reg_write)
                retire_data <= (rd == 5'd0) ? '0 : wb_data;
            else if (ctrl.data_write)
                retire_data <= reg_b;
            else
                retire_data <= '0;
        end
    end

endmodule

/* src/mem_arbiter.sv */
`include "rv_settings.svh"

module mem_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_valid,
    input  logic [`RV_XLEN-1:0] load_addr,
    input  logic [`RV_XLEN-1:0] load_data,
    output logic                load_ready,
    mem_port_if.arb_side        fetch,
    mem_port_if.arb_side        data,
    mem_port_if.mem_master      mem
);

    localparam int QD        = `RV_MEM_QUEUE_DEPTH;
    localparam int TAG_DEPTH = QD + `RV_MEM_LATENCY;
    localparam int TAG_PTR_W = $clog2(TAG_DEPTH);
    localparam int CREDIT_W  = $clog2(QD + 1);

    logic [CREDIT_W-1:0]  credits;
    logic                 has_credit;
    logic                 grant_data;
    logic                 grant_fetch;
    logic                 grant_load;
    rv_pkg::requester_e   winner;
    rv_pkg::requester_e   tag_q [TAG_DEPTH];
    logic [TAG_PTR_W-1:0] tag_wr;
    logic [TAG_PTR_W-1:0] tag_rd;

    // fixed priority, data over fetch over loader
    assign has_credit  = credits != '0;
    assign grant_data  = has_credit && data.req_valid;
    assign grant_fetch = has_credit && fetch.req_valid && !data.req_valid;
    assign grant_load  = has_credit && load_valid && !data.req_valid && !fetch.req_valid;

    assign data.req_ready  = grant_data;
    assign fetch.req_ready = grant_fetch;
    assign load_ready      = grant_load;

    always_comb begin
        mem.req_valid = grant_data || grant_fetch || grant_load;
        winner        = rv_pkg::LOADER;
        mem.req_write = 1'b1;
        mem.req_addr  = load_addr;
        mem.req_wdata = load_data;
        if (grant_data) begin
            winner        = rv_pkg::DATA;
            mem.req_write = data.req_write;
            mem.req_addr  = data.req_addr;
            mem.req_wdata = data.req_wdata;
        end else if (grant_fetch) begin
            winner        = rv_pkg::FETCH;
            mem.req_write = fetch.req_write;
            mem.req_addr  = fetch.req_addr;
            mem.req_wdata = fetch.req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_W'(QD);
            tag_wr  <= '0;
            tag_rd  <= '0;
        end else begin
            if (mem.req_valid && !mem.credit_return)
                credits <= credits - 1'b1;
            else if (!mem.req_valid && mem.credit_return)
                credits <= credits + 1'b1;
            if (mem.req_valid && !mem.req_write)
                tag_wr <= (tag_wr == TAG_PTR_W'(TAG_DEPTH - 1)) ? '0 : tag_wr + 1'b1;
            if (mem.rsp_valid)
                tag_rd <= (tag_rd == TAG_PTR_W'(TAG_DEPTH - 1)) ? '0 : tag_rd + 1'b1;
        end
    end

    // owner of each outstanding read, oldest at tag_rd
    always_ff @(posedge clk) begin
        if (mem.req_valid && !mem.req_write)
            tag_q[tag_wr] <= winner;
    end

    assign fetch.rsp_valid = mem.rsp_valid && tag_q[tag_rd] == rv_pkg::FETCH;
    assign data.rsp_valid  = mem.rsp_valid && tag_q[tag_rd] == rv_pkg::DATA;
    assign fetch.rsp_rdata = mem.rsp_rdata;
    assign data.rsp_rdata  = mem.rsp_rdata;

endmodule

/* src/unified_mem.sv */
`include "rv_settings.svh"

module unified_mem (
    input logic           clk,
    input logic           reset,
    mem_port_if.mem_slave mem
);

    localparam int QD      = `RV_MEM_QUEUE_DEPTH;
    localparam int LAT     = `RV_MEM_LATENCY;
    localparam int IDX_W   = $clog2(`RV_MEM_WORDS);
    localparam int PTR_W   = $clog2(QD);
    localparam int COUNT_W = $clog2(QD + 1);

    logic                q_write [QD];
    logic [IDX_W-1:0]    q_idx   [QD];
    logic [`RV_XLEN-1:0] q_wdata [QD];
    logic [PTR_W-1:0]    head;
    logic [PTR_W-1:0]    tail;
    logic [COUNT_W-1:0]  count;
    logic                deq;
    logic [`RV_XLEN-1:0] words [`RV_MEM_WORDS];
    logic [LAT-1:0]      rd_valid;
    logic [`RV_XLEN-1:0] rd_data [LAT];

    // head entry drains every cycle
    assign deq               = count != '0;
    assign mem.credit_return = deq;
    assign mem.req_ready     = count != COUNT_W'(QD);
    assign mem.rsp_valid     = rd_valid[LAT-1];
    assign mem.rsp_rdata     = rd_data[LAT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            rd_valid <= '0;
        end else begin
            if (mem.req_valid)
                tail <= (tail == PTR_W'(QD - 1)) ? '0 : tail + 1'b1;
            if (deq)
                head <= (head == PTR_W'(QD - 1)) ? '0 : head + 1'b1;
            if (mem.req_valid && !deq)
                count <= count + 1'b1;
            else if (!mem.req_valid && deq)
                count <= count - 1'b1;
            rd_valid <= {rd_valid[LAT-2:0], deq && !q_write[head]};
        end
    end

    always_ff @(posedge clk) begin
        if (mem.req_valid) begin
            q_write[tail] <= mem.req_write;
            q_idx[tail]   <= mem.req_addr[IDX_W+1:2];
            q_wdata[tail] <= mem.req_wdata;
        end
        if (deq && q_write[head])
            words[q_idx[head]] <= q_wdata[head];
        rd_data[0] <= words[q_idx[head]];
        for (int i = 1; i < LAT; i++)
            rd_data[i] <= rd_data[i-1];
    end

endmodule

/* src/rv_multicycle_top.sv */
`include "rv_settings.svh"

module rv_multicycle_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                load_valid,
    input  logic [`RV_XLEN-1:0] load_addr,
    input  logic [`RV_XLEN-1:0] load_data,
    output logic                load_ready,
    output logic                halted,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data
);

    rv_pkg::ctrl_word_t ctrl;
    rv_pkg::opcode_e    opcode;
    logic [2:0]         funct3;
    logic               funct7_5;
    logic               branch_taken;
    logic               fetch_accept;
    logic               data_accept;
    logic               fetch_rsp_valid;
    logic               data_rsp_valid;

    mem_port_if fetch_if ();
    mem_port_if data_if ();
    mem_port_if mem_if ();

    control_unit u_control (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .opcode          (opcode),
        .funct3          (funct3),
        .funct7_5        (funct7_5),
        .fetch_rsp_valid (fetch_rsp_valid),
        .data_rsp_valid  (data_rsp_valid),
        .fetch_accept    (fetch_accept),
        .data_accept     (data_accept),
        .branch_taken    (branch_taken),
        .ctrl            (ctrl),
        .halted          (halted)
    );

    datapath u_datapath (
        .clk             (clk),
        .reset           (reset),
        .ctrl            (ctrl),
        .opcode          (opcode),
        .funct3          (funct3),
        .funct7_5        (funct7_5),
        .branch_taken    (branch_taken),
        .fetch_accept    (fetch_accept),
        .data_accept     (data_accept),
        .fetch_rsp_valid (fetch_rsp_valid),
        .data_rsp_valid  (data_rsp_valid),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_rd       (retire_rd),
        .retire_data     (retire_data),
        .fetch           (fetch_if.requester),
        .data            (data_if.requester)
    );

    mem_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .load_ready (load_ready),
        .fetch      (fetch_if.arb_side),
        .data       (data_if.arb_side),
        .mem        (mem_if.mem_master)
    );

    unified_mem u_mem (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_if.mem_slave)
    );

endmodule

/* tb/rv_sva.sv */
`include "rv_settings.svh"

module rv_sva #(
    parameter int CREDIT_W = $clog2(`RV_MEM_QUEUE_DEPTH + 1)
) (
    input logic                clk,
    input logic                reset,
    input logic [CREDIT_W-1:0] credits,
    input logic                issue,
    input logic                mem_ready,
    input logic                data_ready,
    input logic                fetch_ready,
    input logic                load_ready,
    input logic                fetch_valid,
    input logic [`RV_XLEN-1:0] fetch_addr,
    input logic                data_valid,
    input logic [`RV_XLEN-1:0] data_addr,
    input logic                load_valid,
    input logic [`RV_XLEN-1:0] load_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    // a request needs a free queue slot in the memory
    issue_needs_credit: assert property (@(posedge clk) disable iff (reset)
        issue |-> mem_ready)
        else $error("request sent to memory while its queue was full");

    credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_W'(`RV_MEM_QUEUE_DEPTH))
        else $error("credit count above the memory queue depth");

    single_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({data_ready, fetch_ready, load_ready}))
        else $error("more than one requester granted in a cycle");

    // waiting requesters hold their request
    fetch_hold: assert property (@(posedge clk) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_addr))
        else $error("fetch request changed before it was accepted");

    data_hold: assert property (@(posedge clk) disable iff (reset)
        data_valid && !data_ready |=> data_valid && $stable(data_addr))
        else $error("data request changed before it was accepted");

    load_hold: assert property (@(posedge clk) disable iff (reset)
        load_valid && !load_ready |=> load_valid && $stable(load_addr))
        else $error("loader request changed before it was accepted");

endmodule

bind mem_arbiter rv_sva arbiter_checks (
    .clk         (clk),
    .reset       (reset),
    .credits     (credits),
    .issue       (mem.req_valid),
    .mem_ready   (mem.req_ready),
    .data_ready  (data.req_ready),
    .fetch_ready (fetch.req_ready),
    .load_ready  (load_ready),
    .fetch_valid (fetch.req_valid),
    .fetch_addr  (fetch.req_addr),
    .data_valid  (data.req_valid),
    .data_addr   (data.req_addr),
    .load_valid  (load_valid),
    .load_addr   (load_addr)
);

/* tb/rv_tb.sv */
`include "rv_settings.svh"

module rv_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int SETTLE         = 1;
    localparam int QUIET_CYCLES   = 20;
    localparam int PROG_LEN       = 28;
    localparam int ROWS           = 22;
    localparam int TIMEOUT_CYCLES = (PROG_LEN + ROWS * (12 + `RV_MEM_LATENCY)) * 4;

    localparam logic [31:0] DATA_ADDR = 32'h0000_0100;
    localparam logic [31:0] DATA_WORD = 32'h1357_9bdf;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } retire_row_t;

    // arithmetic, x0 handling, loads and stores, then branches and jumps
    localparam logic [31:0] PROGRAM [PROG_LEN] = '{
        32'h0050_0093, 32'hffd0_0113, 32'h0020_81b3, 32'h4020_8233,
        32'h0011_22b3, 32'h00f0_c313, 32'h0070_8013, 32'h0010_03b3,
        32'h0041_e433, 32'h0043_74b3, 32'h0f01_7513, 32'h1000_e593,
        32'hffc1_2613, 32'h1000_2683, 32'h1040_2223, 32'h1040_2703,
        32'h0070_8463, 32'h0010_0793, 32'h0070_9463, 32'h00c0_086f,
        32'h0020_0793, 32'h0030_0793, 32'h0680_0893, 32'h0008_8967,
        32'h0040_0793, 32'h0050_0793, 32'h00e6_89b3, 32'h0000_0073
    };

    // pc, rd, value written (store data for sw, zero for branches)
    localparam retire_row_t EXPECTED [ROWS] = '{
        {32'h00, 5'd1,  32'h0000_0005},
        {32'h04, 5'd2,  32'hffff_fffd},
        {32'h08, 5'd3,  32'h0000_0002},
        {32'h0c, 5'd4,  32'h0000_0008},
        {32'h10, 5'd5,  32'h0000_0001},
        {32'h14, 5'd6,  32'h0000_000a},
        {32'h18, 5'd0,  32'h0000_0000},
        {32'h1c, 5'd7,  32'h0000_0005},
        {32'h20, 5'd8,  32'h0000_000a},
        {32'h24, 5'd9,  32'h0000_0008},
        {32'h28, 5'd10, 32'h0000_00f0},
        {32'h2c, 5'd11, 32'h0000_0105},
        {32'h30, 5'd12, 32'h0000_0000},
        {32'h34, 5'd13, 32'h1357_9bdf},
        {32'h38, 5'd0,  32'h0000_0008},
        {32'h3c, 5'd14, 32'h0000_0008},
        {32'h40, 5'd0,  32'h0000_0000},
        {32'h48, 5'd0,  32'h0000_0000},
        {32'h4c, 5'd16, 32'h0000_0050},
        {32'h58, 5'd17, 32'h0000_0068},
        {32'h5c, 5'd18, 32'h0000_0060},
        {32'h68, 5'd19, 32'h1357_9be7}
    };

    logic        clk;
    logic        reset;
    logic        start;
    logic        load_valid;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        load_ready;
    logic        halted;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    int          cycle_count;

    rv_multicycle_top dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .load_ready   (load_ready),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int row,
                                   input logic [31:0] expected, input logic [31:0] actual);
        abort_run($sformatf("mismatch %s row %0d: expected %h, actual %h",
                            name, row, expected, actual));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
            abort_run($sformatf("timeout: the core did not halt within %0d cycles",
                                TIMEOUT_CYCLES));
    end

    // hold the write until the arbiter grants the loader
    task automatic load_word(input logic [31:0] addr, input logic [31:0] word);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = word;
        #SETTLE;
        while (!load_ready) begin
            @(negedge clk);
            #SETTLE;
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic wait_retire();
        do
            @(negedge clk);
        while (!retire_valid);
    endtask

    task automatic check_row(input int row);
        retire_row_t exp;
        exp = EXPECTED[row];
        assert (retire_pc == exp.pc)
            else report_mismatch("retire_pc", row, exp.pc, retire_pc);
        assert (retire_rd == exp.rd)
            else report_mismatch("retire_rd", row, 32'(exp.rd), 32'(retire_rd));
        assert (retire_data == exp.data)
            else report_mismatch("retire_data", row, exp.data, retire_data);
    endtask

    initial begin
        int unsigned gap;
        void'($urandom(32'ha90c));
        clk         = 1'b0;
        cycle_count = 0;
        reset       = 1'b1;
        start       = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < PROG_LEN; i++) begin
            load_word(32'(i * 4), PROGRAM[i]);
            gap = $urandom % 3;
            repeat (gap) @(negedge clk);
        end
        load_word(DATA_ADDR, DATA_WORD);

        start = 1'b1;
        @(negedge clk);
        start = 1'b0;

        for (int row = 0; row < ROWS; row++) begin
            wait_retire();
            check_row(row);
        end

        // ecall retires nothing, the core just halts
        while (!halted) begin
            @(negedge clk);
            assert (!retire_valid)
                else abort_run("extra retire beat before the core halted");
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (!retire_valid)
                else abort_run("retire beat seen after the core halted");
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* build.f */
+incdir+common
common/rv_pkg.sv
common/mem_port_if.sv
control/control_unit.sv
datapath/datapath.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/rv_multicycle_top.sv
tb/rv_sva.sv
tb/rv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the RV32I multicycle core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rv_tb -f build.f -o rv_sim

# the simulator exits non-zero on a failure, the log search decides the result
./obj_dir/rv_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
